//--- source/mure_pkg.sv
// ----------------------------------------------------------------------
// shared widths, privilege encodings and sizes for the trace ingress
// reach every item by scoped name, nothing is imported
// ----------------------------------------------------------------------
package mure_pkg;

    // data widths
    localparam int unsigned XLEN      = 32; // address and tval
    localparam int unsigned INST_LEN  = 32; // opcode
    localparam int unsigned CAUSE_LEN = 32; // msb flags an interrupt
    localparam int unsigned PRIV_LEN  = 2;

    // privilege levels as the core reports them
    localparam logic [PRIV_LEN-1:0] PRIV_U = 2'd0;
    localparam logic [PRIV_LEN-1:0] PRIV_S = 2'd1;
    localparam logic [PRIV_LEN-1:0] PRIV_M = 2'd3;

    // retire group and buffering
    localparam int unsigned RETIRE_WIDTH = 2; // 1 to 4 supported
    localparam int unsigned GROUP_DEPTH  = 4; // groups held in the serializer

    // encoder flow control
    localparam int unsigned TRACE_CREDITS = 4; // beats granted after reset
    localparam int unsigned CREDIT_W      = 3; // must hold TRACE_CREDITS

    // no compressed instructions, fixed step
    localparam int unsigned INST_BYTES = 4;

endpackage

//--- source/retire_sampler.sv
// ----------------------------------------------------------------------
// samples the core retire and trap ports through next, current and
// previous stages; trap cause and tval are chosen by privilege level
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module retire_sampler (
    input  logic                                               clk_i,
    input  logic                                               rst_ni,
    // core side, sampled every edge
    input  logic [mure_pkg::RETIRE_WIDTH-1:0]                  valids_i,
    input  logic [mure_pkg::RETIRE_WIDTH*mure_pkg::INST_LEN-1:0] uops_i,
    input  logic                                               exception_i,
    input  logic                                               eret_i,
    input  logic                                               virt_i,
    input  logic [mure_pkg::CAUSE_LEN-1:0]                     ucause_i,
    input  logic [mure_pkg::CAUSE_LEN-1:0]                     scause_i,
    input  logic [mure_pkg::CAUSE_LEN-1:0]                     vscause_i,
    input  logic [mure_pkg::CAUSE_LEN-1:0]                     mcause_i,
    input  logic [mure_pkg::XLEN-1:0]                          utval_i,
    input  logic [mure_pkg::XLEN-1:0]                          stval_i,
    input  logic [mure_pkg::XLEN-1:0]                          vstval_i,
    input  logic [mure_pkg::XLEN-1:0]                          mtval_i,
    input  logic [mure_pkg::PRIV_LEN-1:0]                      priv_lvl_i,
    input  logic [mure_pkg::XLEN-1:0]                          pc_i,
    // group toward the serializer
    output logic                                               grp_push_o,
    output logic [mure_pkg::RETIRE_WIDTH-1:0]                  grp_valids_o,
    output logic [mure_pkg::RETIRE_WIDTH*mure_pkg::INST_LEN-1:0] grp_uops_o,
    output logic                                               grp_exception_o,
    output logic                                               grp_eret_o,
    output logic [mure_pkg::CAUSE_LEN-1:0]                     grp_cause_o,
    output logic [mure_pkg::XLEN-1:0]                          grp_tval_o,
    output logic [mure_pkg::XLEN-1:0]                          grp_pc_o
);

    // next stage, raw copy of the core ports
    logic [mure_pkg::RETIRE_WIDTH-1:0]                    valids_nc;
    logic [mure_pkg::RETIRE_WIDTH*mure_pkg::INST_LEN-1:0] uops_nc;
    logic                                                 exc_nc, eret_nc, virt_nc;
    logic [mure_pkg::PRIV_LEN-1:0]                        priv_nc;
    logic [mure_pkg::CAUSE_LEN-1:0]                       ucause_nc, scause_nc;
    logic [mure_pkg::CAUSE_LEN-1:0]                       vscause_nc, mcause_nc;
    logic [mure_pkg::XLEN-1:0]                            utval_nc, stval_nc;
    logic [mure_pkg::XLEN-1:0]                            vstval_nc, mtval_nc;
    logic [mure_pkg::XLEN-1:0]                            iaddr_nc;

    // current stage holds only the selected trap registers
    logic [mure_pkg::RETIRE_WIDTH-1:0]                    valids_cc;
    logic [mure_pkg::RETIRE_WIDTH*mure_pkg::INST_LEN-1:0] uops_cc;
    logic                                                 exc_cc, eret_cc;
    logic [mure_pkg::CAUSE_LEN-1:0]                       cause_sel, cause_cc;
    logic [mure_pkg::XLEN-1:0]                            tval_sel, tval_cc;
    logic [mure_pkg::XLEN-1:0]                            iaddr_cc;

    // trap mode picks which cause/tval pair is meaningful
    always_comb begin
        case (priv_nc)
            mure_pkg::PRIV_M: begin
                cause_sel = mcause_nc;
                tval_sel  = mtval_nc;
            end
            mure_pkg::PRIV_S: begin
                cause_sel = virt_nc ? vscause_nc : scause_nc; // guest kernel uses vs regs
                tval_sel  = virt_nc ? vstval_nc  : stval_nc;
            end
            default: begin // user
                cause_sel = ucause_nc;
                tval_sel  = utval_nc;
            end
        endcase
    end

    // control flags of all three stages
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valids_nc       <= '0;
            exc_nc          <= 1'b0;
            eret_nc         <= 1'b0;
            valids_cc       <= '0;
            exc_cc          <= 1'b0;
            eret_cc         <= 1'b0;
            grp_valids_o    <= '0;
            grp_exception_o <= 1'b0;
            grp_eret_o      <= 1'b0;
        end else begin
            valids_nc       <= valids_i;
            exc_nc          <= exception_i;
            eret_nc         <= eret_i;
            valids_cc       <= valids_nc;
            exc_cc          <= exc_nc;
            eret_cc         <= eret_nc;
            grp_valids_o    <= valids_cc;
            grp_exception_o <= exc_cc;
            grp_eret_o      <= eret_cc;
        end
    end

    // payload moves along with the flags
    always_ff @(posedge clk_i) begin
        uops_nc    <= uops_i;
        virt_nc    <= virt_i;
        priv_nc    <= priv_lvl_i;
        ucause_nc  <= ucause_i;
        scause_nc  <= scause_i;
        vscause_nc <= vscause_i;
        mcause_nc  <= mcause_i;
        utval_nc   <= utval_i;
        stval_nc   <= stval_i;
        vstval_nc  <= vstval_i;
        mtval_nc   <= mtval_i;
        iaddr_nc   <= pc_i;
        uops_cc    <= uops_nc;
        cause_cc   <= cause_sel;
        tval_cc    <= tval_sel;
        iaddr_cc   <= iaddr_nc;
        grp_uops_o  <= uops_cc;
        grp_cause_o <= cause_cc;
        grp_tval_o  <= tval_cc;
        grp_pc_o    <= iaddr_cc;
    end

    // previous stage holds a group when anything retired or trapped
    assign grp_push_o = (|grp_valids_o) | grp_exception_o;

endmodule

//--- source/retire_serializer.sv
// ----------------------------------------------------------------------
// buffers retire groups and unrolls them into single beats for the
// trace encoder, one beat per cycle while encoder credits remain
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module retire_serializer (
    input  logic                                               clk_i,
    input  logic                                               rst_ni,
    // group from the sampler
    input  logic                                               grp_push_i,
    input  logic [mure_pkg::RETIRE_WIDTH-1:0]                  grp_valids_i,
    input  logic [mure_pkg::RETIRE_WIDTH*mure_pkg::INST_LEN-1:0] grp_uops_i,
    input  logic                                               grp_exception_i,
    input  logic                                               grp_eret_i,
    input  logic [mure_pkg::CAUSE_LEN-1:0]                     grp_cause_i,
    input  logic [mure_pkg::XLEN-1:0]                          grp_tval_i,
    input  logic [mure_pkg::XLEN-1:0]                          grp_pc_i,
    // one pulse per beat consumed downstream
    input  logic                                               credit_i,
    // beat toward the encoder
    output logic                                               inst_valid_o,
    output logic                                               iretired_o,
    output logic                                               exception_o,
    output logic                                               interrupt_o,
    output logic                                               eret_o,
    output logic [mure_pkg::INST_LEN-1:0]                      inst_data_o,
    output logic [mure_pkg::XLEN-1:0]                          pc_o,
    output logic [mure_pkg::XLEN-1:0]                          epc_o,
    output logic [mure_pkg::CAUSE_LEN-1:0]                     cause_o,
    output logic [mure_pkg::XLEN-1:0]                          tval_o,
    output logic                                               overflow_o
);

    localparam int unsigned PTR_W = (mure_pkg::GROUP_DEPTH > 1) ?
                                    $clog2(mure_pkg::GROUP_DEPTH) : 1;
    localparam int unsigned IDX_W = $clog2(mure_pkg::RETIRE_WIDTH + 1);

    // group storage
    logic [mure_pkg::RETIRE_WIDTH-1:0]                    valids_mem [mure_pkg::GROUP_DEPTH];
    logic [mure_pkg::RETIRE_WIDTH*mure_pkg::INST_LEN-1:0] uops_mem   [mure_pkg::GROUP_DEPTH];
    logic                                                 exc_mem    [mure_pkg::GROUP_DEPTH];
    logic                                                 eret_mem   [mure_pkg::GROUP_DEPTH];
    logic [mure_pkg::CAUSE_LEN-1:0]                       cause_mem  [mure_pkg::GROUP_DEPTH];
    logic [mure_pkg::XLEN-1:0]                            tval_mem   [mure_pkg::GROUP_DEPTH];
    logic [mure_pkg::XLEN-1:0]                            pc_mem     [mure_pkg::GROUP_DEPTH];

    logic [PTR_W-1:0]              wr_ptr_q, rd_ptr_q;
    logic [PTR_W:0]                count_q;
    logic [IDX_W-1:0]              idx_q;     // next instruction of the head group
    logic [IDX_W-1:0]              n_valid;   // retired count of the head group
    logic [mure_pkg::CREDIT_W-1:0] credit_q;
    logic                          full, empty, push_ok;
    logic                          beat, trap_beat, last_inst, pop;
    logic [mure_pkg::INST_LEN-1:0] head_uop;
    logic [mure_pkg::XLEN-1:0]     idx_off, n_off;

    assign full    = (count_q == mure_pkg::GROUP_DEPTH);
    assign empty   = (count_q == '0);
    assign push_ok = grp_push_i && !full; // full buffer drops the group

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            valids_mem[wr_ptr_q] <= grp_valids_i;
            uops_mem[wr_ptr_q]   <= grp_uops_i;
            exc_mem[wr_ptr_q]    <= grp_exception_i;
            eret_mem[wr_ptr_q]   <= grp_eret_i;
            cause_mem[wr_ptr_q]  <= grp_cause_i;
            tval_mem[wr_ptr_q]   <= grp_tval_i;
            pc_mem[wr_ptr_q]     <= grp_pc_i;
        end
    end

    // valid bits are contiguous, so a popcount gives the count
    always_comb begin
        n_valid = '0;
        for (int i = 0; i < mure_pkg::RETIRE_WIDTH; i++) begin
            if (valids_mem[rd_ptr_q][i]) n_valid = n_valid + 1'b1;
        end
    end

    assign beat      = !empty && (credit_q != '0);
    assign trap_beat = (idx_q == n_valid);         // all retires done, trap left
    assign last_inst = (idx_q + 1'b1 == n_valid);
    assign pop       = beat && (trap_beat || (last_inst && !exc_mem[rd_ptr_q]));

    assign head_uop = uops_mem[rd_ptr_q][idx_q*mure_pkg::INST_LEN +: mure_pkg::INST_LEN];
    assign idx_off  = idx_q * mure_pkg::INST_BYTES;
    assign n_off    = n_valid * mure_pkg::INST_BYTES;

    // pointers, index, credits and sticky overflow
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            idx_q      <= '0;
            credit_q   <= mure_pkg::CREDIT_W'(mure_pkg::TRACE_CREDITS);
            overflow_o <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(mure_pkg::GROUP_DEPTH - 1)) ?
                            '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(mure_pkg::GROUP_DEPTH - 1)) ?
                            '0 : rd_ptr_q + 1'b1;
                idx_q    <= '0;
            end else if (beat) begin
                idx_q <= idx_q + 1'b1;
            end
            count_q <= count_q + push_ok - pop;
            case ({credit_i, beat})
                2'b10:   credit_q <= credit_q + 1'b1;
                2'b01:   credit_q <= credit_q - 1'b1;
                default: credit_q <= credit_q; // both or neither cancel out
            endcase
            if (grp_push_i && full) overflow_o <= 1'b1;
        end
    end

    // beat flags, inst_valid marks any beat
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            inst_valid_o <= 1'b0;
            iretired_o   <= 1'b0;
            exception_o  <= 1'b0;
            interrupt_o  <= 1'b0;
            eret_o       <= 1'b0;
        end else begin
            inst_valid_o <= beat;
            iretired_o   <= beat && !trap_beat;
            exception_o  <= beat && trap_beat;
            interrupt_o  <= beat && trap_beat && cause_mem[rd_ptr_q][mure_pkg::CAUSE_LEN-1];
            eret_o       <= beat && !trap_beat && last_inst && eret_mem[rd_ptr_q];
        end
    end

    // beat payload, held between beats
    always_ff @(posedge clk_i) begin
        if (beat) begin
            pc_o <= pc_mem[rd_ptr_q] + idx_off;
            if (!trap_beat) begin
                inst_data_o <= head_uop;
            end else begin
                epc_o   <= pc_mem[rd_ptr_q] + n_off; // first unretired address
                cause_o <= cause_mem[rd_ptr_q];
                tval_o  <= tval_mem[rd_ptr_q];
            end
        end
    end

endmodule

//--- source/multiple_retire.sv
// ----------------------------------------------------------------------
// trace ingress top, core retire ports in, serialized beats out
// toward the encoder, which returns one credit per beat
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module multiple_retire (
    input  logic                                               clk_i,
    input  logic                                               rst_ni,
    // core
    input  logic [mure_pkg::RETIRE_WIDTH-1:0]                  valids_i,
    input  logic [mure_pkg::RETIRE_WIDTH*mure_pkg::INST_LEN-1:0] uops_i,
    input  logic                                               exception_i,
    input  logic                                               eret_i,
    input  logic                                               virt_i,
    input  logic [mure_pkg::CAUSE_LEN-1:0]                     ucause_i,
    input  logic [mure_pkg::CAUSE_LEN-1:0]                     scause_i,
    input  logic [mure_pkg::CAUSE_LEN-1:0]                     vscause_i,
    input  logic [mure_pkg::CAUSE_LEN-1:0]                     mcause_i,
    input  logic [mure_pkg::XLEN-1:0]                          utval_i,
    input  logic [mure_pkg::XLEN-1:0]                          stval_i,
    input  logic [mure_pkg::XLEN-1:0]                          vstval_i,
    input  logic [mure_pkg::XLEN-1:0]                          mtval_i,
    input  logic [mure_pkg::PRIV_LEN-1:0]                      priv_lvl_i,
    input  logic [mure_pkg::XLEN-1:0]                          pc_i,
    // encoder
    input  logic                                               credit_i,
    output logic                                               inst_valid_o,
    output logic                                               iretired_o,
    output logic                                               exception_o,
    output logic                                               interrupt_o,
    output logic                                               eret_o,
    output logic [mure_pkg::INST_LEN-1:0]                      inst_data_o,
    output logic [mure_pkg::XLEN-1:0]                          pc_o,
    output logic [mure_pkg::XLEN-1:0]                          epc_o,
    output logic [mure_pkg::CAUSE_LEN-1:0]                     cause_o,
    output logic [mure_pkg::XLEN-1:0]                          tval_o,
    output logic                                               overflow_o
);

    // sampled group, one push per group
    logic                                                 grp_push;
    logic [mure_pkg::RETIRE_WIDTH-1:0]                    grp_valids;
    logic [mure_pkg::RETIRE_WIDTH*mure_pkg::INST_LEN-1:0] grp_uops;
    logic                                                 grp_exception, grp_eret;
    logic [mure_pkg::CAUSE_LEN-1:0]                       grp_cause;
    logic [mure_pkg::XLEN-1:0]                            grp_tval, grp_pc;

    retire_sampler i_sampler (
        .clk_i, .rst_ni,
        .valids_i, .uops_i, .exception_i, .eret_i, .virt_i,
        .ucause_i, .scause_i, .vscause_i, .mcause_i,
        .utval_i, .stval_i, .vstval_i, .mtval_i,
        .priv_lvl_i, .pc_i,
        .grp_push_o      (grp_push),
        .grp_valids_o    (grp_valids),
        .grp_uops_o      (grp_uops),
        .grp_exception_o (grp_exception),
        .grp_eret_o      (grp_eret),
        .grp_cause_o     (grp_cause),
        .grp_tval_o      (grp_tval),
        .grp_pc_o        (grp_pc)
    );

    // one beat per cycle after the push, credit gated
    retire_serializer i_serializer (
        .clk_i, .rst_ni,
        .grp_push_i      (grp_push),
        .grp_valids_i    (grp_valids),
        .grp_uops_i      (grp_uops),
        .grp_exception_i (grp_exception),
        .grp_eret_i      (grp_eret),
        .grp_cause_i     (grp_cause),
        .grp_tval_i      (grp_tval),
        .grp_pc_i        (grp_pc),
        .credit_i,
        .inst_valid_o, .iretired_o, .exception_o, .interrupt_o, .eret_o,
        .inst_data_o, .pc_o, .epc_o, .cause_o, .tval_o,
        .overflow_o
    );

endmodule

//--- test/multiple_retire_asserts.sv
// ----------------------------------------------------------------------
// protocol assertions on the encoder side of the trace ingress,
// attached to multiple_retire with bind
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module multiple_retire_asserts (
    input logic clk_i,
    input logic rst_ni,
    input logic credit_i,
    input logic inst_valid_i,
    input logic iretired_i,
    input logic exception_i,
    input logic interrupt_i,
    input logic eret_i,
    input logic overflow_i
);

    int unsigned fail_cnt = 0; // failed assertions so far
    int          outstanding_q; // beats seen minus credits returned

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            outstanding_q <= 0;
        end else begin
            outstanding_q <= outstanding_q + (inst_valid_i ? 1 : 0) - (credit_i ? 1 : 0);
        end
    end

    // all control outputs quiet while reset is held
    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> !(inst_valid_i || iretired_i || exception_i || interrupt_i ||
                      eret_i || overflow_i))
        else begin
            fail_cnt++;
            $error("control output high during reset");
        end

    // encoder never holds more beats than it granted
    a_credit_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (outstanding_q >= 0) && (outstanding_q <= mure_pkg::TRACE_CREDITS))
        else begin
            fail_cnt++;
            $error("outstanding beats %0d outside credit range", outstanding_q);
        end

    // a beat is either a retire or a trap, never both
    a_beat_kind: assert property (@(posedge clk_i) disable iff (!rst_ni)
        inst_valid_i |-> (iretired_i ^ exception_i))
        else begin
            fail_cnt++;
            $error("beat is not exactly one of retire and trap");
        end

    // sticky until reset
    a_overflow_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
        overflow_i |=> overflow_i)
        else begin
            fail_cnt++;
            $error("overflow flag dropped without reset");
        end

endmodule

bind multiple_retire multiple_retire_asserts i_asserts (
    .clk_i, .rst_ni, .credit_i,
    .inst_valid_i (inst_valid_o),
    .iretired_i   (iretired_o),
    .exception_i  (exception_o),
    .interrupt_i  (interrupt_o),
    .eret_i       (eret_o),
    .overflow_i   (overflow_o)
);

//--- test/tb_multiple_retire.sv
// ----------------------------------------------------------------------
// testbench for the trace ingress, random retire groups in, beats
// checked in order against a queue model, encoder credits modelled
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_multiple_retire;

    typedef struct packed {
        bit                             trap;  // trap beat, else retire
        bit                             eret;
        bit                             intr;
        logic [mure_pkg::INST_LEN-1:0]  data;
        logic [mure_pkg::XLEN-1:0]      pc;    // epc on a trap beat
        logic [mure_pkg::CAUSE_LEN-1:0] cause;
        logic [mure_pkg::XLEN-1:0]      tval;
    } beat_t;

    logic clk_i, rst_ni, credit_i;
    logic [mure_pkg::RETIRE_WIDTH-1:0]                    valids_i;
    logic [mure_pkg::RETIRE_WIDTH*mure_pkg::INST_LEN-1:0] uops_i;
    logic exception_i, eret_i, virt_i;
    logic [mure_pkg::CAUSE_LEN-1:0] ucause_i, scause_i, vscause_i, mcause_i;
    logic [mure_pkg::XLEN-1:0]      utval_i, stval_i, vstval_i, mtval_i, pc_i;
    logic [mure_pkg::PRIV_LEN-1:0]  priv_lvl_i;
    logic inst_valid_o, iretired_o, exception_o, interrupt_o, eret_o, overflow_o;
    logic [mure_pkg::INST_LEN-1:0]  inst_data_o;
    logic [mure_pkg::XLEN-1:0]      pc_o, epc_o, tval_o;
    logic [mure_pkg::CAUSE_LEN-1:0] cause_o;

    int          seed = 22147;
    int          cyc = 0;
    int unsigned cycle_limit = 4000; // about 10x the stimulus length
    int          err_cnt = 0, other_cnt = 0;
    string       test_name = "reset";
    beat_t       staged_q[$], exp_q[$]; // not yet pushed / accepted and expected
    int          grp_cyc_q[$], grp_len_q[$], inflight_q[$], due_q[$];
    int          last_due = -1, delay, due, len, held_beats = 0, n_inst;
    bit          hold_credits = 0, ovf_exp = 0, drop;
    beat_t       exp_b, stg_b;
    logic [mure_pkg::PRIV_LEN-1:0] priv_sel;

    multiple_retire i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // one group on the core ports, its beats staged until the push cycle
    task automatic send_group(input int n, input bit exc, input bit eret,
                              input logic [mure_pkg::PRIV_LEN-1:0] priv,
                              input bit virt, input bit intr);
        beat_t b;
        @(negedge clk_i);
        valids_i = '0;
        for (int i = 0; i < n; i++) valids_i[i] = 1'b1;
        for (int i = 0; i < mure_pkg::RETIRE_WIDTH; i++)
            uops_i[i*mure_pkg::INST_LEN +: mure_pkg::INST_LEN] = $random(seed);
        pc_i = $random(seed) & ~32'h3;        // word aligned
        {ucause_i, scause_i, vscause_i, mcause_i} = {$random(seed), $random(seed),
                                                    $random(seed), $random(seed)};
        ucause_i[mure_pkg::CAUSE_LEN-1]  = intr;
        scause_i[mure_pkg::CAUSE_LEN-1]  = intr;
        vscause_i[mure_pkg::CAUSE_LEN-1] = intr;
        mcause_i[mure_pkg::CAUSE_LEN-1]  = intr;
        {utval_i, stval_i, vstval_i, mtval_i} = {$random(seed), $random(seed),
                                                $random(seed), $random(seed)};
        {exception_i, eret_i, virt_i, priv_lvl_i} = {exc, eret, virt, priv};
        for (int i = 0; i < n; i++) begin
            b      = '0;
            b.data = uops_i[i*mure_pkg::INST_LEN +: mure_pkg::INST_LEN];
            b.pc   = pc_i + i * mure_pkg::INST_BYTES;
            b.eret = eret && (i == n - 1); // only the last retire
            staged_q.push_back(b);
        end
        if (exc) begin
            b      = '0;
            b.trap = 1'b1;
            b.pc   = pc_i + n * mure_pkg::INST_BYTES; // first address not retired
            if (priv == mure_pkg::PRIV_M) {b.cause, b.tval} = {mcause_i, mtval_i};
            else if (priv == mure_pkg::PRIV_S && virt) {b.cause, b.tval} = {vscause_i, vstval_i};
            else if (priv == mure_pkg::PRIV_S) {b.cause, b.tval} = {scause_i, stval_i};
            else {b.cause, b.tval} = {ucause_i, utval_i};
            b.intr = intr;
            staged_q.push_back(b);
        end
        grp_cyc_q.push_back(cyc + 3); // push lands on the fourth edge
        grp_len_q.push_back(n + (exc ? 1 : 0));
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            {valids_i, exception_i, eret_i} = '0;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || grp_cyc_q.size() != 0 || due_q.size() != 0)
            @(negedge clk_i);
        @(negedge clk_i); // last credit sampled
    endtask

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc == cycle_limit) begin
            $display("timeout after %0d cycles, %0d beats still expected", cyc, exp_q.size());
            $display("errors: %0d value, %0d other, %0d assertion",
                     err_cnt, other_cnt, i_dut.i_asserts.fail_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // model: beat compare, group acceptance, encoder credits
    always @(negedge clk_i) begin
        if (rst_ni) begin
            check_val("overflow_o", ovf_exp, overflow_o);
            if (inst_valid_o) begin
                if (exp_q.size() == 0) begin
                    other_cnt++;
                    $display("[%s] the DUT sent a beat that the model did not expect", test_name);
                end else begin
                    exp_b = exp_q.pop_front();
                    check_val("exception_o", exp_b.trap, exception_o);
                    check_val("iretired_o", !exp_b.trap, iretired_o);
                    check_val("eret_o", exp_b.eret, eret_o);
                    if (exp_b.trap) begin
                        check_val("epc_o", exp_b.pc, epc_o);
                        check_val("cause_o", exp_b.cause, cause_o);
                        check_val("tval_o", exp_b.tval, tval_o);
                        check_val("interrupt_o", exp_b.intr, interrupt_o);
                    end else begin
                        check_val("pc_o", exp_b.pc, pc_o);
                        check_val("inst_data_o", exp_b.data, inst_data_o);
                    end
                end
                if (inflight_q.size() > 0) begin
                    inflight_q[0] = inflight_q[0] - 1;
                    if (inflight_q[0] == 0) void'(inflight_q.pop_front()); // group popped
                end
                if (hold_credits) held_beats++;
                delay = $unsigned($random(seed)) % 4; // credit 0..3 cycles later
                due   = (cyc + delay > last_due) ? cyc + delay : last_due + 1;
                last_due = due;
                due_q.push_back(due);
            end
            if (grp_cyc_q.size() > 0 && grp_cyc_q[0] == cyc) begin
                void'(grp_cyc_q.pop_front());
                len  = grp_len_q.pop_front();
                drop = (inflight_q.size() >= mure_pkg::GROUP_DEPTH); // full buffer
                if (drop) ovf_exp = 1'b1;
                else inflight_q.push_back(len);
                repeat (len) begin
                    stg_b = staged_q.pop_front();
                    if (!drop) exp_q.push_back(stg_b);
                end
            end
        end
        if (!hold_credits && due_q.size() > 0 && due_q[0] <= cyc) begin
            credit_i = 1'b1;
            void'(due_q.pop_front());
        end else begin
            credit_i = 1'b0;
        end
    end

    initial begin
        rst_ni = 1'b0;
        credit_i = 1'b0;
        {virt_i, eret_i, priv_lvl_i, uops_i, pc_i} = '0;
        {ucause_i, scause_i, vscause_i, mcause_i, utval_i, stval_i, vstval_i, mtval_i} = '0;
        valids_i    = '1; // busy core during reset, nothing may leak
        exception_i = 1'b1;
        repeat (5) @(negedge clk_i);
        {valids_i, exception_i} = '0;
        rst_ni = 1'b1;
        idle(4);
        test_name = "serialize";
        repeat (40) begin
            n_inst = 1 + $unsigned($random(seed)) % mure_pkg::RETIRE_WIDTH;
            send_group(n_inst, 1'b0, 1'b0, mure_pkg::PRIV_M, 1'b0, 1'b0);
            idle(n_inst + $unsigned($random(seed)) % 2);
        end
        wait_drain();
        test_name = "trap";
        for (int p = 0; p < 3; p++) begin
            priv_sel = (p == 0) ? mure_pkg::PRIV_U :
                       (p == 1) ? mure_pkg::PRIV_S : mure_pkg::PRIV_M;
            for (int v = 0; v < 2; v++) begin
                for (int it = 0; it < 2; it++) begin
                    n_inst = $unsigned($random(seed)) % (mure_pkg::RETIRE_WIDTH + 1);
                    send_group(n_inst, 1'b1, 1'b0, priv_sel, v[0], it[0]);
                    idle(n_inst + 2);
                end
            end
        end
        wait_drain();
        test_name = "eret";
        repeat (6) begin
            n_inst = 1 + $unsigned($random(seed)) % mure_pkg::RETIRE_WIDTH;
            send_group(n_inst, 1'b0, 1'b1, mure_pkg::PRIV_S, 1'b0, 1'b0);
            idle(n_inst + 1);
        end
        wait_drain();
        test_name    = "credit";
        hold_credits = 1'b1; // encoder stops returning credits
        held_beats   = 0;
        repeat (3) send_group(2, 1'b0, 1'b0, mure_pkg::PRIV_S, 1'b0, 1'b0);
        idle(1);
        while (held_beats < mure_pkg::TRACE_CREDITS) @(negedge clk_i);
        idle(12);
        check_val("beats without credits", mure_pkg::TRACE_CREDITS, held_beats);
        hold_credits = 1'b0;
        wait_drain();
        test_name = "overflow";
        check_val("overflow_o before burst", 32'd0, overflow_o);
        hold_credits = 1'b1;
        repeat (10) send_group(1, 1'b0, 1'b0, mure_pkg::PRIV_U, 1'b0, 1'b0);
        idle(5); // past the 3-edge sampler latency
        check_val("overflow_o after burst", 32'd1, overflow_o);
        hold_credits = 1'b0;
        wait_drain();
        idle(4);
        check_val("overflow_o after drain", 32'd1, overflow_o);
        $display("errors: %0d value, %0d other, %0d assertion",
                 err_cnt, other_cnt, i_dut.i_asserts.fail_cnt);
        if (err_cnt == 0 && other_cnt == 0 && i_dut.i_asserts.fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- mure_trace.f
source/mure_pkg.sv
source/retire_sampler.sv
source/retire_serializer.sv
source/multiple_retire.sv
test/multiple_retire_asserts.sv
test/tb_multiple_retire.sv
